/* logic/sysPkg.sv */
`default_nettype none

package sysPkg;

    // Data path sizes
    localparam int DATA_W    = 8;
    localparam int ADDR_W    = 4;
    localparam int REG_DEPTH = 16;

    typedef logic [DATA_W-1:0]   dataT;
    typedef logic [ADDR_W-1:0]   addrT;
    typedef logic [2*DATA_W-1:0] resultT;

    // Serial bit timing, fixed in place of a prescaler
    localparam int BIT_CYCLES = 16;
    localparam int BIT_CNT_W  = $clog2(BIT_CYCLES);

    typedef logic [BIT_CNT_W-1:0] bitCntT;

    // Last count of a full bit and of half a bit
    localparam bitCntT BIT_LAST  = bitCntT'(BIT_CYCLES - 1);
    localparam bitCntT HALF_LAST = bitCntT'(BIT_CYCLES / 2 - 1);

    // Command opcodes, first byte of every frame sequence
    typedef enum logic [7:0] {
        CMD_WR_REG  = 8'hAA,
        CMD_RD_REG  = 8'hBB,
        CMD_ALU_OPS = 8'hCC,
        CMD_ALU_FN  = 8'hDD
    } cmdT;

    typedef enum logic [2:0] {
        FN_ADD, FN_SUB, FN_MUL, FN_DIV, FN_AND, FN_OR, FN_XOR, FN_CMP
    } aluFunT;

    // Register map
    localparam addrT REG_OP_A  = 4'd0;
    localparam addrT REG_OP_B  = 4'd1;
    localparam addrT REG_CFG   = 4'd2;
    // Parity on, even
    localparam dataT CFG_RESET = 8'h01;

endpackage

`default_nettype wire

/* logic/uartRx.sv */
`default_nettype none
`timescale 1ns/1ps

module uartRx (
    input  wire          REF_CLK,
    input  wire          rstN,
    input  wire          rxIn,
    input  wire          parityEn,
    input  wire          parityOdd,
    output sysPkg::dataT rxData,
    output logic         rxValid,
    output logic         parityErr,
    output logic         stopErr
);
    import sysPkg::*;

    typedef enum logic [2:0] {
        ST_IDLE, ST_START, ST_DATA, ST_PARITY, ST_STOP
    } rxStateT;

    rxStateT    state;
    bitCntT     cnt;
    logic [2:0] idx;
    // Input synchronizer plus one stage for edge detection
    logic [2:0] rxSync;
    dataT       shReg;
    logic       parBit;
    logic       rxBit;
    logic       fallEdge;
    logic       parBad;

    assign rxBit    = rxSync[1];
    assign fallEdge = rxSync[2] & ~rxSync[1];
    // Data bits xor parity bit must match the configured sense
    assign parBad   = parityEn && ((^shReg ^ parBit) != parityOdd);
    assign rxData   = shReg;

    always_ff @(posedge REF_CLK or negedge rstN) begin
        if (!rstN) begin
            rxSync    <= 3'b111;
            state     <= ST_IDLE;
            cnt       <= '0;
            idx       <= '0;
            shReg     <= '0;
            parBit    <= 1'b0;
            rxValid   <= 1'b0;
            parityErr <= 1'b0;
            stopErr   <= 1'b0;
        end else begin
            rxSync    <= {rxSync[1:0], rxIn};
            rxValid   <= 1'b0;
            parityErr <= 1'b0;
            stopErr   <= 1'b0;
            cnt       <= cnt + 1'b1;
            case (state)
                ST_IDLE: begin
                    cnt <= '0;
                    if (fallEdge) begin
                        state <= ST_START;
                    end
                end
                // Confirm the start bit at its middle, else treat as a glitch
                ST_START: begin
                    if (cnt == HALF_LAST) begin
                        cnt   <= '0;
                        idx   <= '0;
                        state <= rxBit ? ST_IDLE : ST_DATA;
                    end
                end
                // LSB first, one sample per bit centre
                ST_DATA: begin
                    if (cnt == BIT_LAST) begin
                        cnt   <= '0;
                        shReg <= {rxBit, shReg[DATA_W-1:1]};
                        idx   <= idx + 1'b1;
                        if (idx == 3'd7) begin
                            state <= parityEn ? ST_PARITY : ST_STOP;
                        end
                    end
                end
                ST_PARITY: begin
                    if (cnt == BIT_LAST) begin
                        cnt    <= '0;
                        parBit <= rxBit;
                        state  <= ST_STOP;
                    end
                end
                // Report at the stop bit centre, a bad frame gives no byte
                ST_STOP: begin
                    if (cnt == BIT_LAST) begin
                        cnt       <= '0;
                        state     <= ST_IDLE;
                        rxValid   <= rxBit && !parBad;
                        parityErr <= parBad;
                        stopErr   <= !rxBit;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    noValidWithParityErr: assert property (
        @(posedge REF_CLK) disable iff (!rstN) !(rxValid && parityErr)
    );

endmodule

`default_nettype wire

/* logic/uartTx.sv */
`default_nettype none
`timescale 1ns/1ps

module uartTx (
    input  wire               REF_CLK,
    input  wire               rstN,
    input  wire               txStart,
    input  wire sysPkg::dataT txData,
    input  wire               parityEn,
    input  wire               parityOdd,
    output logic              txOut,
    output logic              txBusy
);
    import sysPkg::*;

    typedef enum logic [2:0] {
        ST_IDLE, ST_START, ST_DATA, ST_PARITY, ST_STOP
    } txStateT;

    txStateT    state;
    bitCntT     cnt;
    logic [2:0] idx;
    dataT       shReg;
    logic       parBit;
    logic       parEnL;
    logic       bitEnd;

    assign bitEnd = (cnt == BIT_LAST);
    assign txBusy = (state != ST_IDLE);

    always_ff @(posedge REF_CLK or negedge rstN) begin
        if (!rstN) begin
            state  <= ST_IDLE;
            cnt    <= '0;
            idx    <= '0;
            shReg  <= '0;
            parBit <= 1'b0;
            parEnL <= 1'b0;
            txOut  <= 1'b1;
        end else begin
            cnt <= bitEnd ? '0 : cnt + 1'b1;
            case (state)
                // Latch byte and frame format, start bit goes out next cycle
                ST_IDLE: begin
                    cnt <= '0;
                    if (txStart) begin
                        shReg  <= txData;
                        parBit <= ^txData ^ parityOdd;
                        parEnL <= parityEn;
                        txOut  <= 1'b0;
                        state  <= ST_START;
                    end
                end
                ST_START: begin
                    if (bitEnd) begin
                        txOut <= shReg[0];
                        shReg <= shReg >> 1;
                        idx   <= '0;
                        state <= ST_DATA;
                    end
                end
                ST_DATA: begin
                    if (bitEnd) begin
                        idx <= idx + 1'b1;
                        if (idx == 3'd7) begin
                            // Parity bit if enabled, else straight to stop
                            txOut <= parEnL ? parBit : 1'b1;
                            state <= parEnL ? ST_PARITY : ST_STOP;
                        end else begin
                            txOut <= shReg[0];
                            shReg <= shReg >> 1;
                        end
                    end
                end
                ST_PARITY: begin
                    if (bitEnd) begin
                        txOut <= 1'b1;
                        state <= ST_STOP;
                    end
                end
                // Busy drops once the stop bit has ended
                ST_STOP: begin
                    if (bitEnd) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    noStartWhileBusy: assert property (
        @(posedge REF_CLK) disable iff (!rstN) !(txStart && txBusy)
    );

endmodule

`default_nettype wire

/* logic/regFile.sv */
`default_nettype none
`timescale 1ns/1ps

module regFile (
    input  wire               REF_CLK,
    input  wire               rstN,
    input  wire               wrEn,
    input  wire               rdEn,
    input  wire sysPkg::addrT addr,
    input  wire sysPkg::dataT wrData,
    output sysPkg::dataT      rdData,
    output logic              rdValid,
    output sysPkg::dataT      opA,
    output sysPkg::dataT      opB,
    output logic              parityEn,
    output logic              parityOdd
);
    import sysPkg::*;

    dataT regs [REG_DEPTH];

    // Operands and frame settings always visible
    assign opA       = regs[REG_OP_A];
    assign opB       = regs[REG_OP_B];
    assign parityEn  = regs[REG_CFG][0];
    assign parityOdd = regs[REG_CFG][1];

    always_ff @(posedge REF_CLK or negedge rstN) begin
        if (!rstN) begin
            // Config register comes up with parity on, even
            for (int i = 0; i < REG_DEPTH; i++) begin
                regs[i] <= (i == REG_CFG) ? CFG_RESET : '0;
            end
            rdData  <= '0;
            rdValid <= 1'b0;
        end else begin
            rdValid <= 1'b0;
            if (wrEn) begin
                regs[addr] <= wrData;
            end else if (rdEn) begin
                // Registered read, one cycle latency
                rdData  <= regs[addr];
                rdValid <= 1'b1;
            end
        end
    end

    noWriteWithRead: assert property (
        @(posedge REF_CLK) disable iff (!rstN) !(wrEn && rdEn)
    );

endmodule

`default_nettype wire

/* logic/alu.sv */
`default_nettype none
`timescale 1ns/1ps

module alu (
    input  wire                 REF_CLK,
    input  wire                 rstN,
    input  wire                 aluEn,
    input  wire sysPkg::aluFunT aluFun,
    input  wire sysPkg::dataT   opA,
    input  wire sysPkg::dataT   opB,
    output sysPkg::resultT      aluOut,
    output logic                aluValid
);
    import sysPkg::*;

    resultT result;

    always_comb begin
        result = '0;
        case (aluFun)
            FN_ADD: result = resultT'(opA) + resultT'(opB);
            // Wraps in 16 bits when B exceeds A
            FN_SUB: result = resultT'(opA) - resultT'(opB);
            FN_MUL: result = resultT'(opA) * resultT'(opB);
            // Divide by zero yields zero
            FN_DIV: result = (opB == '0) ? '0 : resultT'(opA / opB);
            FN_AND: result = {{DATA_W{1'b0}}, opA & opB};
            FN_OR:  result = {{DATA_W{1'b0}}, opA | opB};
            FN_XOR: result = {{DATA_W{1'b0}}, opA ^ opB};
            // Compare codes 1 greater, 2 equal, 3 less
            FN_CMP: begin
                if (opA > opB) begin
                    result = 16'd1;
                end else if (opA == opB) begin
                    result = 16'd2;
                end else begin
                    result = 16'd3;
                end
            end
            default: result = '0;
        endcase
    end

    // Result held until the next operation
    always_ff @(posedge REF_CLK or negedge rstN) begin
        if (!rstN) begin
            aluOut   <= '0;
            aluValid <= 1'b0;
        end else begin
            aluValid <= aluEn;
            if (aluEn) begin
                aluOut <= result;
            end
        end
    end

endmodule

`default_nettype wire

/* logic/sysCtrl.sv */
`default_nettype none
`timescale 1ns/1ps

module sysCtrl (
    input  wire                 REF_CLK,
    input  wire                 rstN,
    input  wire sysPkg::dataT   rxData,
    input  wire                 rxValid,
    output logic                wrEn,
    output logic                rdEn,
    output sysPkg::addrT        addr,
    output sysPkg::dataT        wrData,
    input  wire sysPkg::dataT   rdData,
    input  wire                 rdValid,
    output logic                aluEn,
    output sysPkg::aluFunT      aluFun,
    input  wire sysPkg::resultT aluOut,
    input  wire                 aluValid,
    output sysPkg::dataT        txData,
    output logic                txStart,
    input  wire                 txBusy
);
    import sysPkg::*;

    typedef enum logic [3:0] {
        ST_IDLE, ST_WR_ADDR, ST_WR_DATA, ST_RD_ADDR, ST_OP_A, ST_OP_B, ST_OP_FUN,
        ST_WR_B, ST_ALU_GO, ST_FN_ONLY, ST_WAIT_RES, ST_SEND, ST_SEND_WAIT
    } ctrlStateT;

    ctrlStateT state;
    dataT      opAL;
    dataT      opBL;
    // Reply buffer, low byte first for ALU results
    dataT      replyLo;
    dataT      replyHi;
    logic      replyTwo;
    logic      replySel;

    always_ff @(posedge REF_CLK or negedge rstN) begin
        if (!rstN) begin
            state    <= ST_IDLE;
            wrEn     <= 1'b0;
            rdEn     <= 1'b0;
            aluEn    <= 1'b0;
            txStart  <= 1'b0;
            addr     <= '0;
            wrData   <= '0;
            aluFun   <= FN_ADD;
            txData   <= '0;
            opAL     <= '0;
            opBL     <= '0;
            replyLo  <= '0;
            replyHi  <= '0;
            replyTwo <= 1'b0;
            replySel <= 1'b0;
        end else begin
            // Request strobes are single cycle
            wrEn    <= 1'b0;
            rdEn    <= 1'b0;
            aluEn   <= 1'b0;
            txStart <= 1'b0;
            case (state)
                // Non-opcode bytes are dropped here
                ST_IDLE: begin
                    if (rxValid) begin
                        case (cmdT'(rxData))
                            CMD_WR_REG:  state <= ST_WR_ADDR;
                            CMD_RD_REG:  state <= ST_RD_ADDR;
                            CMD_ALU_OPS: state <= ST_OP_A;
                            CMD_ALU_FN:  state <= ST_FN_ONLY;
                            default:     state <= ST_IDLE;
                        endcase
                    end
                end
                ST_WR_ADDR: begin
                    if (rxValid) begin
                        addr  <= rxData[ADDR_W-1:0];
                        state <= ST_WR_DATA;
                    end
                end
                // Write has no reply
                ST_WR_DATA: begin
                    if (rxValid) begin
                        wrData <= rxData;
                        wrEn   <= 1'b1;
                        state  <= ST_IDLE;
                    end
                end
                ST_RD_ADDR: begin
                    if (rxValid) begin
                        addr  <= rxData[ADDR_W-1:0];
                        rdEn  <= 1'b1;
                        state <= ST_WAIT_RES;
                    end
                end
                ST_OP_A: begin
                    if (rxValid) begin
                        opAL  <= rxData;
                        state <= ST_OP_B;
                    end
                end
                ST_OP_B: begin
                    if (rxValid) begin
                        opBL  <= rxData;
                        state <= ST_OP_FUN;
                    end
                end
                // Operand A write goes out with the function byte
                ST_OP_FUN: begin
                    if (rxValid) begin
                        aluFun <= aluFunT'(rxData[$bits(aluFunT)-1:0]);
                        addr   <= REG_OP_A;
                        wrData <= opAL;
                        wrEn   <= 1'b1;
                        state  <= ST_WR_B;
                    end
                end
                ST_WR_B: begin
                    addr   <= REG_OP_B;
                    wrData <= opBL;
                    wrEn   <= 1'b1;
                    state  <= ST_ALU_GO;
                end
                // Both writes land before the ALU samples
                ST_ALU_GO: begin
                    aluEn <= 1'b1;
                    state <= ST_WAIT_RES;
                end
                // Works on registers 0 and 1 as they stand
                ST_FN_ONLY: begin
                    if (rxValid) begin
                        aluFun <= aluFunT'(rxData[$bits(aluFunT)-1:0]);
                        aluEn  <= 1'b1;
                        state  <= ST_WAIT_RES;
                    end
                end
                ST_WAIT_RES: begin
                    replySel <= 1'b0;
                    if (rdValid) begin
                        replyLo  <= rdData;
                        replyTwo <= 1'b0;
                        state    <= ST_SEND;
                    end else if (aluValid) begin
                        replyLo  <= aluOut[DATA_W-1:0];
                        replyHi  <= aluOut[2*DATA_W-1:DATA_W];
                        replyTwo <= 1'b1;
                        state    <= ST_SEND;
                    end
                end
                ST_SEND: begin
                    if (!txBusy) begin
                        txData  <= replySel ? replyHi : replyLo;
                        txStart <= 1'b1;
                        state   <= ST_SEND_WAIT;
                    end
                end
                // Busy rises only after the start pulse, so skip that cycle
                ST_SEND_WAIT: begin
                    if (!txStart && !txBusy) begin
                        if (replyTwo && !replySel) begin
                            replySel <= 1'b1;
                            state    <= ST_SEND;
                        end else begin
                            state <= ST_IDLE;
                        end
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    singleResultSource: assert property (
        @(posedge REF_CLK) disable iff (!rstN) !(rdValid && aluValid)
    );

endmodule

`default_nettype wire

/* logic/sysTop.sv */
`default_nettype none
`timescale 1ns/1ps

module sysTop (
    input  wire  REF_CLK,
    input  wire  rstN,
    input  wire  rxIn,
    output logic txOut,
    output logic parityError,
    output logic stopError
);
    import sysPkg::*;

    // Receiver to controller
    dataT   rxData;
    logic   rxValid;
    // Controller and register file
    logic   wrEn;
    logic   rdEn;
    addrT   addr;
    dataT   wrData;
    dataT   rdData;
    logic   rdValid;
    dataT   opA;
    dataT   opB;
    // Live frame settings from register 2
    logic   parityEn;
    logic   parityOdd;
    // Controller and ALU
    logic   aluEn;
    aluFunT aluFun;
    resultT aluOut;
    logic   aluValid;
    // Controller to transmitter
    dataT   txData;
    logic   txStart;
    logic   txBusy;

    uartRx rxInst (
        .REF_CLK(REF_CLK), .rstN(rstN), .rxIn(rxIn),
        .parityEn(parityEn), .parityOdd(parityOdd),
        .rxData(rxData), .rxValid(rxValid),
        .parityErr(parityError), .stopErr(stopError)
    );

    sysCtrl ctrlInst (
        .REF_CLK(REF_CLK), .rstN(rstN), .rxData(rxData), .rxValid(rxValid),
        .wrEn(wrEn), .rdEn(rdEn), .addr(addr), .wrData(wrData),
        .rdData(rdData), .rdValid(rdValid),
        .aluEn(aluEn), .aluFun(aluFun), .aluOut(aluOut), .aluValid(aluValid),
        .txData(txData), .txStart(txStart), .txBusy(txBusy)
    );

    regFile regFileInst (
        .REF_CLK(REF_CLK), .rstN(rstN), .wrEn(wrEn), .rdEn(rdEn),
        .addr(addr), .wrData(wrData), .rdData(rdData), .rdValid(rdValid),
        .opA(opA), .opB(opB), .parityEn(parityEn), .parityOdd(parityOdd)
    );

    alu aluInst (
        .REF_CLK(REF_CLK), .rstN(rstN), .aluEn(aluEn), .aluFun(aluFun),
        .opA(opA), .opB(opB), .aluOut(aluOut), .aluValid(aluValid)
    );

    uartTx txInst (
        .REF_CLK(REF_CLK), .rstN(rstN), .txStart(txStart), .txData(txData),
        .parityEn(parityEn), .parityOdd(parityOdd),
        .txOut(txOut), .txBusy(txBusy)
    );

endmodule

`default_nettype wire

/* verif/sysTopTb.sv */
`default_nettype none
`timescale 1ns/1ps

module sysTopTb;
    import sysPkg::*;

    typedef enum logic [1:0] {
        ERR_NONE, ERR_PARITY, ERR_STOP
    } errKindT;

    // Stimulus line layout and capacity
    localparam int LINE_W    = 9;
    localparam int MAX_LINES = 32;

    logic refClk;
    logic rstN;
    logic rxIn;
    logic txOut;
    logic parityError;
    logic stopError;

    // Word 0 is the line count, then LINE_W bytes per line
    dataT        stim [1 + LINE_W * MAX_LINES];
    dataT        replyBytes [$];
    int          lineCount   = 0;
    bit          loaded      = 1'b0;
    bit          replyActive = 1'b0;
    // Host side copy of the frame format in register 2
    logic        parEnM;
    logic        parOddM;
    int          parCount    = 0;
    int          stopCount   = 0;
    int          byteErrors  = 0;
    int          flagErrors  = 0;
    int          frameErrors = 0;
    int          countErrors = 0;
    int unsigned seedVal;

    sysTop i_dut (
        .REF_CLK(refClk), .rstN(rstN), .rxIn(rxIn), .txOut(txOut),
        .parityError(parityError), .stopError(stopError)
    );

    initial refClk = 1'b0;
    always #2 refClk = ~refClk;

    // Error pulses are counted where they are stable
    always @(negedge refClk) begin
        if (parityError === 1'b1) begin
            parCount <= parCount + 1;
        end
        if (stopError === 1'b1) begin
            stopCount <= stopCount + 1;
        end
    end

    task automatic driveBit(input logic level);
        rxIn = level;
        repeat (BIT_CYCLES) @(negedge refClk);
    endtask

    // Start, 8 data bits LSB first, optional parity, stop
    task automatic sendByte(input dataT value, input errKindT corrupt);
        logic parBit;
        parBit = ^value ^ parOddM;
        if (corrupt == ERR_PARITY) begin
            parBit = ~parBit;
        end
        driveBit(1'b0);
        for (int k = 0; k < DATA_W; k++) begin
            driveBit(value[k]);
        end
        if (parEnM) begin
            driveBit(parBit);
        end
        driveBit(corrupt != ERR_STOP);
        // Line back to idle so the next start bit is a real edge
        if (corrupt == ERR_STOP) begin
            driveBit(1'b1);
        end
    endtask

    task automatic checkByte(input dataT expected, input dataT actual, input string what);
        if (actual !== expected) begin
            byteErrors++;
            $display("MISMATCH at %0t ns: %s expected %02h got %02h",
                     $time, what, expected, actual);
        end
    endtask

    task automatic checkFlag(input errKindT expected, input errKindT actual, input string what);
        if (actual !== expected) begin
            flagErrors++;
            $display("MISMATCH at %0t ns: %s expected %s got %s",
                     $time, what, expected.name(), actual.name());
        end
    endtask

    task automatic printCounts();
        $display("Errors: byte %0d, flag %0d, frame %0d, count %0d",
                 byteErrors, flagErrors, frameErrors, countErrors);
    endtask

    task automatic runLine(input int line);
        int      base;
        int      nBytes;
        int      nRep;
        int      startIdx;
        int      parBefore;
        int      stopBefore;
        int      gap;
        errKindT kind;
        errKindT seen;
        base       = 1 + line * LINE_W;
        kind       = errKindT'(stim[base][1:0]);
        nBytes     = int'(stim[base + 1]);
        nRep       = int'(stim[base + 6]);
        startIdx   = replyBytes.size();
        parBefore  = parCount;
        stopBefore = stopCount;
        for (int k = 0; k < nBytes; k++) begin
            sendByte(stim[base + 2 + k], kind);
        end
        // Error pulses land at the stop bit centre, before sendByte returns
        if (parCount != parBefore) begin
            seen = ERR_PARITY;
        end else if (stopCount != stopBefore) begin
            seen = ERR_STOP;
        end else begin
            seen = ERR_NONE;
        end
        checkFlag(kind, seen, $sformatf("line %0d error flag", line));
        // Frame format follows a write to the config register
        if (kind == ERR_NONE && stim[base + 2] == dataT'(CMD_WR_REG)
                && stim[base + 3][ADDR_W-1:0] == REG_CFG) begin
            parEnM  = stim[base + 4][0];
            parOddM = stim[base + 4][1];
        end
        while (replyBytes.size() < startIdx + nRep) begin
            @(negedge refClk);
        end
        // Idle gap also gives a stray reply time to show up
        gap = int'($urandom_range(3, 0));
        repeat ((gap + 2) * BIT_CYCLES) @(negedge refClk);
        if (replyActive || replyBytes.size() != startIdx + nRep) begin
            countErrors++;
            $display("Line %0d got %0d reply bytes where %0d were expected", line,
                     replyBytes.size() - startIdx, nRep);
        end else begin
            for (int k = 0; k < nRep; k++) begin
                checkByte(stim[base + 7 + k], replyBytes[startIdx + k],
                          $sformatf("line %0d reply byte %0d", line, k));
            end
        end
    endtask

    initial begin
        rstN    = 1'b0;
        rxIn    = 1'b1;
        parEnM  = CFG_RESET[0];
        parOddM = CFG_RESET[1];
        seedVal = $urandom(55);
        $readmemh("verif/sysStimulus.txt", stim);
        lineCount = int'(stim[0]);
        if (lineCount == 0 || lineCount > MAX_LINES) begin
            $display("Stimulus file gave an unusable line count of %0d", lineCount);
            countErrors++;
            lineCount = 0;
        end
        loaded = 1'b1;
        repeat (8) @(negedge refClk);
        rstN = 1'b1;
        repeat (4) @(negedge refClk);
        for (int i = 0; i < lineCount; i++) begin
            runLine(i);
        end
        printCounts();
        if (byteErrors + flagErrors + frameErrors + countErrors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    // Reply receiver, samples txOut at bit centres
    initial begin : replyReceiver
        dataT rxByte;
        wait (rstN === 1'b1);
        forever begin
            @(negedge refClk);
            if (txOut === 1'b0) begin
                replyActive = 1'b1;
                repeat (BIT_CYCLES / 2) @(negedge refClk);
                if (txOut !== 1'b0) begin
                    frameErrors++;
                    $display("Reply start bit was not low at its centre, time %0t ns", $time);
                end
                for (int k = 0; k < DATA_W; k++) begin
                    repeat (BIT_CYCLES) @(negedge refClk);
                    rxByte[k] = txOut;
                end
                if (parEnM) begin
                    repeat (BIT_CYCLES) @(negedge refClk);
                    if (txOut !== (^rxByte ^ parOddM)) begin
                        frameErrors++;
                        $display("Reply parity bit was wrong, time %0t ns", $time);
                    end
                end
                repeat (BIT_CYCLES) @(negedge refClk);
                if (txOut !== 1'b1) begin
                    frameErrors++;
                    $display("Reply stop bit was low, time %0t ns", $time);
                end
                replyBytes.push_back(rxByte);
                replyActive = 1'b0;
            end
        end
    end

    // Watchdog sized from the number of stimulus lines
    initial begin
        wait (loaded);
        repeat (lineCount * 8 * 12 * BIT_CYCLES + 1000) @(posedge refClk);
        $display("Timeout: the run did not finish in the allowed number of clock periods");
        printCounts();
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* verif/sysStimulus.txt */
// Line count first, then kind nBytes cmd0 cmd1 cmd2 cmd3 nReply exp0 exp1
// Kind 0 is a good command, 1 a byte with bad parity, 2 a byte with a low stop bit
18
00 02 BB 02 00 00 01 01 00
00 02 BB 05 00 00 01 00 00
00 03 AA 05 5A 00 00 00 00
00 02 BB 05 00 00 01 5A 00
00 04 CC C8 64 00 02 2C 01
00 04 CC 10 20 01 02 F0 FF
00 04 CC FF FF 02 02 01 FE
00 04 CC 64 07 03 02 0E 00
00 04 CC 64 00 03 02 00 00
00 04 CC F0 3C 04 02 30 00
00 04 CC F0 0C 05 02 FC 00
00 04 CC AA 0F 06 02 A5 00
00 04 CC 10 20 07 02 03 00
00 02 DD 00 00 00 02 30 00
00 04 CC 42 42 07 02 02 00
01 01 BB 00 00 00 00 00 00
02 01 AA 00 00 00 00 00 00
00 02 BB 05 00 00 01 5A 00
00 03 AA 02 00 00 00 00 00
00 04 CC 80 7F 07 02 01 00
00 03 AA 02 03 00 00 00 00
00 02 DD 01 00 00 02 01 00
01 01 CC 00 00 00 00 00 00
00 02 BB 02 00 00 01 03 00

/* sources.f */
logic/sysPkg.sv
logic/uartRx.sv
logic/uartTx.sv
logic/regFile.sv
logic/alu.sv
logic/sysCtrl.sv
logic/sysTop.sv
verif/sysTopTb.sv

/* Makefile */
VERILATOR  ?= verilator
SIM_FLAGS  ?= --binary --timing
LINT_FLAGS ?= --lint-only --timing -Wall
TOP        ?= sysTopTb
FILE_LIST  ?= sources.f
BUILD_DIR  ?= obj_dir
PASS_MSG   := TESTBENCH PASSED

.PHONY: lint build sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILE_LIST)

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(BUILD_DIR)

# Pass only if the simulation output holds the pass line
sim: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
